// File: hw/rename_pkg.sv
package rename_pkg;

    localparam int NICK_W = 4;
    localparam int REG_NUM = 32;
    localparam int ROB_DEPTH_DEFAULT = 8; // top level allows 2 to 15

    typedef logic [31:0] data_t;
    typedef logic [4:0] reg_name_t;
    typedef logic [NICK_W-1:0] nick_t; // zero means the register is current
    typedef logic [5:0] op_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] imm_t;

    // stores carry an rd field that names no destination
    localparam op_t OP_SB = 6'd24;
    localparam op_t OP_SH = 6'd25;
    localparam op_t OP_SW = 6'd26;

    // true when the instruction produces a register result that needs a rename
    function automatic logic writes_reg(input op_t op, input reg_name_t rd);
        logic is_store;
        is_store = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
        return (rd != '0) && !is_store;
    endfunction

endpackage

// File: hw/reg_rename_file.sv
`timescale 1ns/1ps

module reg_rename_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  clr,
    input  logic                  inst_en,
    input  rename_pkg::reg_name_t rs1,
    input  rename_pkg::reg_name_t rs2,
    input  rename_pkg::reg_name_t rd,
    input  rename_pkg::op_t       op,
    input  rename_pkg::addr_t     pc,
    input  rename_pkg::imm_t      imm,
    input  logic                  pd,
    input  rename_pkg::nick_t     alloc_nick,
    input  logic                  rob_full,
    input  logic                  commit_en,
    input  rename_pkg::reg_name_t commit_rd,
    input  rename_pkg::nick_t     commit_nick,
    input  rename_pkg::data_t     commit_dt,
    output logic                  dp_en,
    output rename_pkg::data_t     raw_rs1_dt,
    output rename_pkg::data_t     raw_rs2_dt,
    output rename_pkg::nick_t     raw_rs1_nick,
    output rename_pkg::nick_t     raw_rs2_nick,
    output rename_pkg::reg_name_t dp_rd,
    output rename_pkg::op_t       dp_op,
    output rename_pkg::addr_t     dp_pc,
    output rename_pkg::imm_t      dp_imm,
    output logic                  dp_pd
);
    import rename_pkg::*;

    data_t regs_dt [REG_NUM];
    nick_t regs_nick [REG_NUM];
    logic  accept;

    // rdy low is a plain stall, so nothing is taken in that cycle
    assign accept = inst_en && rdy && !rob_full && !clr && !rst;
    assign dp_en  = accept;

    always_comb begin
        raw_rs1_dt   = '0; // idle dispatch bundle reads as all zero
        raw_rs2_dt   = '0;
        raw_rs1_nick = '0;
        raw_rs2_nick = '0;
        dp_rd        = '0;
        dp_op        = '0;
        dp_pc        = '0;
        dp_imm       = '0;
        dp_pd        = 1'b0;
        if (accept) begin
            raw_rs1_dt   = regs_dt[rs1];
            raw_rs2_dt   = regs_dt[rs2];
            raw_rs1_nick = regs_nick[rs1];
            raw_rs2_nick = regs_nick[rs2];
            dp_rd        = rd;
            dp_op        = op;
            dp_pc        = pc;
            dp_imm       = imm;
            dp_pd        = pd;
        end
    end

    // register 0 is never written, so it keeps value zero and nick zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_dt[i]   <= '0;
                regs_nick[i] <= '0;
            end
        end else if (clr) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_nick[i] <= '0; // values stay, only the tags go
            end
        end else begin
            if (commit_en && commit_rd != '0) begin
                regs_dt[commit_rd] <= commit_dt;
                // a newer rename of the same register must survive this commit
                if (regs_nick[commit_rd] == commit_nick) begin
                    regs_nick[commit_rd] <= '0;
                end
            end
            if (accept && writes_reg(op, rd)) begin
                regs_nick[rd] <= alloc_nick; // placed last so it wins over the commit clear
            end
        end
    end

endmodule

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  clr,
    input  logic                  alloc,
    input  rename_pkg::reg_name_t alloc_rd,
    input  logic                  alloc_wr,
    input  logic                  wb_en,
    input  rename_pkg::nick_t     wb_nick,
    input  rename_pkg::data_t     wb_data,
    input  rename_pkg::nick_t     look1_nick,
    input  rename_pkg::nick_t     look2_nick,
    output rename_pkg::nick_t     alloc_nick,
    output logic                  rob_full,
    output logic                  look1_done,
    output logic                  look2_done,
    output rename_pkg::data_t     look1_dt,
    output rename_pkg::data_t     look2_dt,
    output logic                  commit_en,
    output rename_pkg::reg_name_t commit_rd,
    output rename_pkg::nick_t     commit_nick,
    output rename_pkg::data_t     commit_dt
);
    import rename_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] wr;
    reg_name_t            rd_q [ROB_DEPTH];
    data_t                dt_q [ROB_DEPTH];
    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [IDX_W-1:0]     wb_idx;
    logic                 do_wb;
    logic                 pop;

    // nick k names entry k-1
    function automatic logic [IDX_W-1:0] nick_idx(input nick_t nick);
        return IDX_W'(nick - 1'b1);
    endfunction

    function automatic logic in_range(input nick_t nick);
        return (nick != '0) && (nick <= ROB_DEPTH);
    endfunction

    function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_nick = nick_t'(tail) + 1'b1;
    assign rob_full   = (count == CNT_W'(ROB_DEPTH));

    assign look1_done = in_range(look1_nick) && busy[nick_idx(look1_nick)]
                        && done[nick_idx(look1_nick)];
    assign look2_done = in_range(look2_nick) && busy[nick_idx(look2_nick)]
                        && done[nick_idx(look2_nick)];
    assign look1_dt   = dt_q[nick_idx(look1_nick)];
    assign look2_dt   = dt_q[nick_idx(look2_nick)];

    // a writeback for an entry that is not in flight is dropped
    assign wb_idx = nick_idx(wb_nick);
    assign do_wb  = wb_en && rdy && !clr && in_range(wb_nick) && busy[wb_idx];

    assign pop         = busy[head] && done[head] && rdy && !clr;
    assign commit_en   = pop && wr[head]; // stores leave without a commit strobe
    assign commit_rd   = rd_q[head];
    assign commit_nick = nick_t'(head) + 1'b1;
    assign commit_dt   = dt_q[head];

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_wb) begin
                done[wb_idx] <= 1'b1;
            end
            if (pop) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= next_ptr(head);
            end
            if (alloc) begin // alloc is only raised when the queue has room
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= next_ptr(tail);
            end
            count <= count + CNT_W'(alloc) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wb) begin
            dt_q[wb_idx] <= wb_data;
        end
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
            wr[tail]   <= alloc_wr;
        end
    end

endmodule

// File: hw/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEFAULT
) (
    input  rename_pkg::data_t raw_rs1_dt,
    input  rename_pkg::data_t raw_rs2_dt,
    input  rename_pkg::nick_t raw_rs1_nick,
    input  rename_pkg::nick_t raw_rs2_nick,
    input  logic              look1_done,
    input  logic              look2_done,
    input  rename_pkg::data_t look1_dt,
    input  rename_pkg::data_t look2_dt,
    input  logic              wb_en,
    input  rename_pkg::nick_t wb_nick,
    input  rename_pkg::data_t wb_data,
    output rename_pkg::nick_t look1_nick,
    output rename_pkg::nick_t look2_nick,
    output rename_pkg::data_t dp_rs1_dt,
    output rename_pkg::data_t dp_rs2_dt,
    output rename_pkg::nick_t dp_rs1_nick,
    output rename_pkg::nick_t dp_rs2_nick
);
    import rename_pkg::*;

    function automatic logic pending(input nick_t nick);
        return (nick != '0) && (nick <= ROB_DEPTH);
    endfunction

    assign look1_nick = raw_rs1_nick;
    assign look2_nick = raw_rs2_nick;

    // a finished buffer entry is preferred over the live writeback bus
    always_comb begin
        dp_rs1_dt   = raw_rs1_dt;
        dp_rs1_nick = raw_rs1_nick;
        if (pending(raw_rs1_nick)) begin
            if (look1_done) begin
                dp_rs1_dt   = look1_dt;
                dp_rs1_nick = '0;
            end else if (wb_en && wb_nick == raw_rs1_nick) begin
                dp_rs1_dt   = wb_data;
                dp_rs1_nick = '0;
            end
        end
    end

    always_comb begin
        dp_rs2_dt   = raw_rs2_dt;
        dp_rs2_nick = raw_rs2_nick;
        if (pending(raw_rs2_nick)) begin
            if (look2_done) begin
                dp_rs2_dt   = look2_dt;
                dp_rs2_nick = '0;
            end else if (wb_en && wb_nick == raw_rs2_nick) begin
                dp_rs2_dt   = wb_data;
                dp_rs2_nick = '0;
            end
        end
    end

endmodule

// File: hw/rename_core.sv
`timescale 1ns/1ps

module rename_core #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  clr,
    input  logic                  inst_en,
    input  rename_pkg::reg_name_t rs1,
    input  rename_pkg::reg_name_t rs2,
    input  rename_pkg::reg_name_t rd,
    input  rename_pkg::op_t       op,
    input  rename_pkg::addr_t     pc,
    input  rename_pkg::imm_t      imm,
    input  logic                  pd,
    input  logic                  wb_en,
    input  rename_pkg::nick_t     wb_nick,
    input  rename_pkg::data_t     wb_data,
    output logic                  dp_en,
    output rename_pkg::data_t     dp_rs1_dt,
    output rename_pkg::data_t     dp_rs2_dt,
    output rename_pkg::nick_t     dp_rs1_nick,
    output rename_pkg::nick_t     dp_rs2_nick,
    output rename_pkg::nick_t     dp_nick,
    output rename_pkg::reg_name_t dp_rd,
    output rename_pkg::op_t       dp_op,
    output rename_pkg::addr_t     dp_pc,
    output rename_pkg::imm_t      dp_imm,
    output logic                  dp_pd,
    output logic                  commit_en,
    output rename_pkg::reg_name_t commit_rd,
    output rename_pkg::data_t     commit_dt,
    output logic                  rob_full
);
    import rename_pkg::*;

    data_t raw_rs1_dt;
    data_t raw_rs2_dt;
    nick_t raw_rs1_nick;
    nick_t raw_rs2_nick;
    nick_t look1_nick;
    nick_t look2_nick;
    logic  look1_done;
    logic  look2_done;
    data_t look1_dt;
    data_t look2_dt;
    nick_t commit_nick;
    logic  alloc_wr;

    assign alloc_wr = writes_reg(dp_op, dp_rd); // same rule the register file renames by

    reg_rename_file rrf_i (
        .clk(clk), .rst(rst), .rdy(rdy), .clr(clr),
        .inst_en(inst_en), .rs1(rs1), .rs2(rs2), .rd(rd),
        .op(op), .pc(pc), .imm(imm), .pd(pd),
        .alloc_nick(dp_nick), .rob_full(rob_full),
        .commit_en(commit_en), .commit_rd(commit_rd),
        .commit_nick(commit_nick), .commit_dt(commit_dt),
        .dp_en(dp_en),
        .raw_rs1_dt(raw_rs1_dt), .raw_rs2_dt(raw_rs2_dt),
        .raw_rs1_nick(raw_rs1_nick), .raw_rs2_nick(raw_rs2_nick),
        .dp_rd(dp_rd), .dp_op(dp_op), .dp_pc(dp_pc),
        .dp_imm(dp_imm), .dp_pd(dp_pd)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk(clk), .rst(rst), .rdy(rdy), .clr(clr),
        .alloc(dp_en), .alloc_rd(dp_rd), .alloc_wr(alloc_wr),
        .wb_en(wb_en), .wb_nick(wb_nick), .wb_data(wb_data),
        .look1_nick(look1_nick), .look2_nick(look2_nick),
        .alloc_nick(dp_nick), .rob_full(rob_full),
        .look1_done(look1_done), .look2_done(look2_done),
        .look1_dt(look1_dt), .look2_dt(look2_dt),
        .commit_en(commit_en), .commit_rd(commit_rd),
        .commit_nick(commit_nick), .commit_dt(commit_dt)
    );

    operand_bypass #(.ROB_DEPTH(ROB_DEPTH)) byp_i (
        .raw_rs1_dt(raw_rs1_dt), .raw_rs2_dt(raw_rs2_dt),
        .raw_rs1_nick(raw_rs1_nick), .raw_rs2_nick(raw_rs2_nick),
        .look1_done(look1_done), .look2_done(look2_done),
        .look1_dt(look1_dt), .look2_dt(look2_dt),
        .wb_en(wb_en), .wb_nick(wb_nick), .wb_data(wb_data),
        .look1_nick(look1_nick), .look2_nick(look2_nick),
        .dp_rs1_dt(dp_rs1_dt), .dp_rs2_dt(dp_rs2_dt),
        .dp_rs1_nick(dp_rs1_nick), .dp_rs2_nick(dp_rs2_nick)
    );

endmodule

// File: sim/rename_checker.sv
`timescale 1ns/1ps

module rename_checker #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  clr,
    input  logic                  inst_en,
    input  rename_pkg::reg_name_t rs1,
    input  rename_pkg::reg_name_t rs2,
    input  rename_pkg::reg_name_t rd,
    input  rename_pkg::op_t       op,
    input  rename_pkg::addr_t     pc,
    input  rename_pkg::imm_t      imm,
    input  logic                  pd,
    input  logic                  wb_en,
    input  rename_pkg::nick_t     wb_nick,
    input  rename_pkg::data_t     wb_data,
    input  logic                  dp_en,
    input  rename_pkg::data_t     dp_rs1_dt,
    input  rename_pkg::data_t     dp_rs2_dt,
    input  rename_pkg::nick_t     dp_rs1_nick,
    input  rename_pkg::nick_t     dp_rs2_nick,
    input  rename_pkg::nick_t     dp_nick,
    input  rename_pkg::reg_name_t dp_rd,
    input  rename_pkg::op_t       dp_op,
    input  rename_pkg::addr_t     dp_pc,
    input  rename_pkg::imm_t      dp_imm,
    input  logic                  dp_pd,
    input  logic                  commit_en,
    input  rename_pkg::reg_name_t commit_rd,
    input  rename_pkg::data_t     commit_dt,
    input  logic                  rob_full,
    output int                    in_flight
);
    import rename_pkg::*;

    data_t     m_dt [REG_NUM]; // committed architectural values
    nick_t     m_nick [REG_NUM];
    logic      m_busy [1 << NICK_W];
    logic      m_done [1 << NICK_W];
    logic      m_wr [1 << NICK_W];
    reg_name_t m_rd [1 << NICK_W];
    data_t     m_val [1 << NICK_W];
    nick_t     order [$]; // in-flight nicks, oldest first
    nick_t     tail_nick;
    int        errors = 0;
    int        test_errors = 0;
    int        tests_run = 0;
    int        tests_bad = 0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // expected {nick, data} of a source register in the current cycle
    function automatic logic [NICK_W+31:0] expected_source(input reg_name_t r);
        nick_t n;
        n = m_nick[r];
        if (r == '0 || n == '0) return {nick_t'(0), m_dt[r]};
        if (m_done[n]) return {nick_t'(0), m_val[n]};
        if (wb_en && wb_nick == n) return {nick_t'(0), wb_data}; // same-cycle writeback
        return {n, m_dt[r]};
    endfunction

    task automatic clear_inflight();
        for (int i = 0; i < (1 << NICK_W); i++) begin
            m_busy[i] = 1'b0;
            m_done[i] = 1'b0;
        end
        order.delete();
        tail_nick = nick_t'(1);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin : model_step
        logic               exp_accept;
        logic               exp_pop;
        logic               exp_commit;
        logic               writes;
        logic [NICK_W+31:0] src1;
        logic [NICK_W+31:0] src2;
        nick_t              head;
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                m_dt[i]   = '0;
                m_nick[i] = '0;
            end
            clear_inflight();
        end else begin
            head       = (order.size() > 0) ? order[0] : '0;
            exp_accept = inst_en && rdy && !clr && (order.size() < ROB_DEPTH);
            exp_pop    = rdy && !clr && m_busy[head] && m_done[head];
            exp_commit = exp_pop && m_wr[head];
            compare("dp_en", dp_en, exp_accept);
            compare("rob_full", rob_full, order.size() == ROB_DEPTH);
            compare("commit_en", commit_en, exp_commit);
            if (exp_accept) begin
                src1 = expected_source(rs1);
                src2 = expected_source(rs2);
                compare("dp_rs1_dt", dp_rs1_dt, src1[31:0]);
                compare("dp_rs1_nick", dp_rs1_nick, src1[NICK_W+31:32]);
                compare("dp_rs2_dt", dp_rs2_dt, src2[31:0]);
                compare("dp_rs2_nick", dp_rs2_nick, src2[NICK_W+31:32]);
                compare("dp_nick", dp_nick, tail_nick);
                compare("dp_rd", dp_rd, rd);
                compare("dp_op", dp_op, op);
                compare("dp_pc", dp_pc, pc);
                compare("dp_imm", dp_imm, imm);
                compare("dp_pd", dp_pd, pd);
            end
            if (exp_commit) begin
                compare("commit_rd", commit_rd, m_rd[head]);
                compare("commit_dt", commit_dt, m_val[head]);
            end
            if (clr) begin
                for (int i = 0; i < REG_NUM; i++) begin
                    m_nick[i] = '0;
                end
                clear_inflight();
            end else begin
                if (exp_pop) begin
                    if (exp_commit) begin
                        m_dt[m_rd[head]] = m_val[head];
                        if (m_nick[m_rd[head]] == head) m_nick[m_rd[head]] = '0;
                    end
                    m_busy[head] = 1'b0;
                    m_done[head] = 1'b0;
                    order.delete(0);
                end
                if (wb_en && rdy && m_busy[wb_nick]) begin
                    m_done[wb_nick] = 1'b1;
                    m_val[wb_nick]  = wb_data;
                end
                if (exp_accept) begin
                    writes = (rd != '0) && (op != OP_SB) && (op != OP_SH) && (op != OP_SW);
                    m_busy[tail_nick] = 1'b1;
                    m_done[tail_nick] = 1'b0;
                    m_rd[tail_nick]   = rd;
                    m_wr[tail_nick]   = writes;
                    if (writes) m_nick[rd] = tail_nick;
                    order.push_back(tail_nick);
                    tail_nick = (tail_nick == nick_t'(ROB_DEPTH)) ? nick_t'(1) : tail_nick + 1'b1;
                end
            end
        end
        in_flight = order.size();
    end

endmodule

// File: sim/rename_core_asserts.sv
`timescale 1ns/1ps

module rename_core_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  dp_en,
    input logic                  rob_full,
    input logic                  commit_en,
    input rename_pkg::reg_name_t rs1,
    input rename_pkg::nick_t     dp_rs1_nick
);
    int fails = 0;

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        !(dp_en && rob_full))
        else begin
            $error("dispatch accepted while rob_full was high");
            fails++;
        end

    // the first cycle after a reset edge is always quiet
    quiet_after_reset: assert property (@(posedge clk) rst |=> (!commit_en && !dp_en))
        else begin
            $error("commit_en or dp_en high right after reset");
            fails++;
        end

    zero_reg_not_renamed: assert property (@(posedge clk) (rs1 == '0) |-> (dp_rs1_nick == '0))
        else begin
            $error("dp_rs1_nick nonzero for register 0");
            fails++;
        end

endmodule

bind rename_core rename_core_asserts asrt_i (.*);

// File: sim/tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core;
    import rename_pkg::*;

    localparam int ROB_DEPTH = ROB_DEPTH_DEFAULT;
    localparam int NUM_TESTS = 5;
    localparam int CYCLE_LIMIT = NUM_TESTS * (ROB_DEPTH + 40);

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      clr;
    logic      inst_en;
    reg_name_t rs1;
    reg_name_t rs2;
    reg_name_t rd;
    op_t       op;
    addr_t     pc;
    imm_t      imm;
    logic      pd;
    logic      wb_en;
    nick_t     wb_nick;
    data_t     wb_data;
    logic      dp_en;
    data_t     dp_rs1_dt;
    data_t     dp_rs2_dt;
    nick_t     dp_rs1_nick;
    nick_t     dp_rs2_nick;
    nick_t     dp_nick;
    reg_name_t dp_rd;
    op_t       dp_op;
    addr_t     dp_pc;
    imm_t      dp_imm;
    logic      dp_pd;
    logic      commit_en;
    reg_name_t commit_rd;
    data_t     commit_dt;
    logic      rob_full;
    int        in_flight;

    logic [31:0] seed;
    int          cycles = 0;
    nick_t       pend [$]; // allocated entries still waiting for their writeback
    reg_name_t   r;
    reg_name_t   r2;
    logic [31:0] coin;
    int          total_errors;

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) rename_core_i (.*);

    rename_checker #(.ROB_DEPTH(ROB_DEPTH)) chk_i (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic reg_name_t rand_reg();
        return reg_name_t'(lcg_next() % 31 + 1);
    endfunction

    function automatic reg_name_t other_reg(input reg_name_t x);
        return (x == 5'd31) ? 5'd1 : x + 1'b1;
    endfunction

    // moves to the next falling edge and returns every strobe to idle
    task automatic next_cycle();
        @(negedge clk);
        inst_en = 1'b0;
        wb_en   = 1'b0;
        clr     = 1'b0;
        rdy     = 1'b1;
    endtask

    task automatic put_inst(input reg_name_t s1, input reg_name_t s2, input reg_name_t d,
                            input op_t o);
        logic [31:0] bits;
        while (rob_full) begin
            next_cycle(); // commits keep going while the source waits
        end
        bits    = lcg_next();
        inst_en = 1'b1;
        rs1     = s1;
        rs2     = s2;
        rd      = d;
        op      = o;
        pc      = lcg_next();
        imm     = lcg_next();
        pd      = bits[0];
    endtask

    task automatic put_wb(input int k);
        wb_en   = 1'b1;
        wb_nick = pend[k];
        wb_data = lcg_next();
        pend.delete(k);
    endtask

    task automatic drain();
        next_cycle();
        while (pend.size() > 0) begin
            put_wb(lcg_next() % pend.size());
            next_cycle();
        end
        while (in_flight != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst || clr) begin
            pend.delete();
        end else if (dp_en) begin
            pend.push_back(dp_nick);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed    = 32'd42;
        rst     = 1'b1;
        rdy     = 1'b1;
        clr     = 1'b0;
        inst_en = 1'b1; // a request held through reset must not dispatch
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        op      = '0;
        pc      = '0;
        imm     = '0;
        pd      = 1'b0;
        wb_en   = 1'b0;
        wb_nick = '0;
        wb_data = '0;
        repeat (4) @(negedge clk);
        rst     = 1'b0;
        inst_en = 1'b0;
        next_cycle();

        r = rand_reg();
        put_inst(rand_reg(), rand_reg(), r, 6'd1);
        drain();
        put_inst(r, r, 5'd0, 6'd2);
        drain();
        chk_i.finish_test("commit then read");

        r = rand_reg();
        put_inst(5'd0, 5'd0, r, 6'd1);
        next_cycle();
        put_inst(r, 5'd0, 5'd0, 6'd2); // producer still unfinished
        next_cycle();
        put_wb(0);
        next_cycle();
        put_inst(r, r, 5'd0, 6'd2); // value comes from the finished buffer entry
        next_cycle();
        r2 = other_reg(r);
        put_inst(5'd0, 5'd0, r2, 6'd1);
        next_cycle();
        put_inst(r2, r, 5'd0, 6'd2);
        put_wb(pend.size() - 1); // writeback in the same cycle as the read
        drain();
        chk_i.finish_test("bypass of unfinished producer");

        r = rand_reg();
        put_inst(5'd0, 5'd0, r, 6'd1);
        next_cycle();
        put_inst(5'd0, 5'd0, r, 6'd1);
        next_cycle();
        put_wb(0);
        next_cycle();
        next_cycle();
        put_inst(r, 5'd0, 5'd0, 6'd2); // older writer has committed, newer rename holds
        next_cycle();
        repeat (14) begin
            coin = lcg_next();
            if (pend.size() > 0 && (rob_full || coin[1])) begin
                put_wb(lcg_next() % pend.size());
            end else begin
                put_inst(rand_reg(), rand_reg(), rand_reg(), op_t'(lcg_next() % 32));
            end
            next_cycle();
        end
        drain();
        chk_i.finish_test("random writeback order");

        r = rand_reg();
        put_inst(5'd0, 5'd0, r, 6'd1);
        next_cycle();
        put_inst(r, 5'd0, r, OP_SW);
        next_cycle();
        put_inst(5'd0, 5'd0, 5'd0, 6'd1);
        next_cycle();
        put_inst(5'd0, r, 5'd0, OP_SB); // register 0 read right after a write to it
        next_cycle();
        put_inst(r, 5'd0, 5'd0, 6'd2);
        drain();
        put_inst(r, 5'd0, 5'd0, 6'd2);
        drain();
        chk_i.finish_test("stores and register zero");

        repeat (ROB_DEPTH) begin
            put_inst(5'd0, 5'd0, rand_reg(), 6'd1);
            next_cycle();
        end
        inst_en = 1'b1; // ignored while the buffer is full
        next_cycle();
        put_wb(0);
        next_cycle();
        put_wb(0); // the finished head commits in this cycle
        next_cycle();
        rdy     = 1'b0; // a stall holds both the new instruction and the finished head
        inst_en = 1'b1;
        next_cycle();
        put_inst(5'd0, 5'd0, rand_reg(), 6'd1);
        next_cycle();
        clr = 1'b1;
        next_cycle();
        repeat (4) begin
            put_inst(rand_reg(), rand_reg(), 5'd0, 6'd2);
            next_cycle();
        end
        drain();
        chk_i.finish_test("full buffer and flush");

        total_errors = chk_i.errors + rename_core_i.asrt_i.fails;
        $display("%0d tests run, %0d with mismatches, %0d mismatches, %0d assertion failures",
                 chk_i.tests_run, chk_i.tests_bad, chk_i.errors, rename_core_i.asrt_i.fails);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/rename_pkg.sv
hw/reg_rename_file.sv
hw/reorder_buffer.sv
hw/operand_bypass.sv
hw/rename_core.sv
sim/rename_checker.sv
sim/rename_core_asserts.sv
sim/tb_rename_core.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - files:
      - hw/rename_pkg.sv
      - hw/reg_rename_file.sv
      - hw/reorder_buffer.sv
      - hw/operand_bypass.sv
      - hw/rename_core.sv
  - target: simulation
    files:
      - sim/rename_checker.sv
      - sim/rename_core_asserts.sv
      - sim/tb_rename_core.sv
